// File: source/lsu_params.svh
// --------------------------------------------------------------------------
// Build-wide sizing for the load/store cluster. LSU_XLEN is fixed at 32.
// LSU_LANES may be 2 to 8, and LSU_LANE_BITS must then cover it.
// RAM address bits above the word index are ignored.
// --------------------------------------------------------------------------
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

`define LSU_LANES      4   // Number of load/store lanes.
`define LSU_XLEN       32  // Data and address width.
`define LSU_RAM_WORDS  64  // RAM depth in words.
`define LSU_LANE_BITS  2   // Width of a lane index.

`endif

// File: source/lsu_pkg.sv
// --------------------------------------------------------------------------
// Shared types for the load/store cluster. The memory word union assumes
// a 32-bit little-endian word, matching LSU_XLEN.
// --------------------------------------------------------------------------
package lsu_pkg;

    // Access width of one load or store.
    typedef enum logic [1:0] {
        LSU_BYTE = 2'd0,                      // 8-bit access.
        LSU_HALF = 2'd1,                      // 16-bit access.
        LSU_WORD = 2'd2                       // 32-bit access.
    } lsu_width_t;

    // One memory word, seen as bytes or as halfwords.
    typedef union packed {
        logic [3:0][7:0]  b;                  // Byte lanes, b[0] is lowest.
        logic [1:0][15:0] h;                  // Halfword lanes.
    } mem_word_t;

endpackage

// File: source/lsu_issue.sv
// --------------------------------------------------------------------------
// One operation slot per lane. A slot fills only when empty and frees when
// its lane completes without hold. Lane indices past LSU_LANES are illegal.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_issue (
    input  logic                                g_clk,
    input  logic                                g_resetn,
    input  logic                                req_valid,
    input  logic [`LSU_LANE_BITS-1:0]           req_lane,
    input  logic                                req_load,
    input  logic                                req_store,
    input  lsu_pkg::lsu_width_t                 req_width,
    input  logic                                req_signed,
    input  logic [`LSU_XLEN-1:0]                req_addr,
    input  logic [`LSU_XLEN-1:0]                req_wdata,
    output logic                                req_ready,
    input  logic [`LSU_LANES-1:0]               res_hold,
    output logic [`LSU_LANES-1:0]               res_valid,
    output logic [`LSU_LANES-1:0]               res_error,
    input  logic [`LSU_LANES-1:0]               lane_ready,
    input  logic [`LSU_LANES-1:0]               lane_a_error,
    output logic [`LSU_LANES-1:0]               lsu_valid,
    output logic [`LSU_LANES-1:0]               lsu_load,
    output logic [`LSU_LANES-1:0]               lsu_store,
    output logic [2*`LSU_LANES-1:0]             lsu_width,
    output logic [`LSU_LANES-1:0]               lsu_signed,
    output logic [`LSU_LANES*`LSU_XLEN-1:0]     lsu_addr,
    output logic [`LSU_LANES*`LSU_XLEN-1:0]     lsu_wdata,
    output logic [`LSU_LANES-1:0]               pipe_prog
);

    logic [`LSU_LANES-1:0] slot_valid;                 // Slot holds an operation.
    logic [`LSU_LANES-1:0] take;                       // One-hot slot fill.

    // ----------------------------------------------------------------------
    // Accept and release
    // ----------------------------------------------------------------------
    assign req_ready = !slot_valid[req_lane];          // Addressed slot empty.
    assign take      = (req_valid && req_ready) ?
                       ({{(`LSU_LANES-1){1'b0}}, 1'b1} << req_lane) : '0;
    assign pipe_prog = lane_ready & ~res_hold;         // Result taken this cycle.
    assign res_valid = lane_ready & slot_valid;
    assign res_error = lane_a_error & slot_valid;      // Misaligned, no access made.
    assign lsu_valid = slot_valid;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            slot_valid <= '0;
        end else begin
            slot_valid <= (slot_valid & ~pipe_prog) | take;
        end
    end

    // Operation payload, written only on fill.
    always_ff @(posedge g_clk) begin
        for (int i = 0; i < `LSU_LANES; i++) begin
            if (take[i]) begin
                lsu_load[i]                      <= req_load;
                lsu_store[i]                     <= req_store;
                lsu_width[2*i +: 2]              <= req_width;
                lsu_signed[i]                    <= req_signed;
                lsu_addr[i*`LSU_XLEN +: `LSU_XLEN]  <= req_addr;
                lsu_wdata[i*`LSU_XLEN +: `LSU_XLEN] <= req_wdata;
            end
        end
    end

    // A full slot keeps its operation until the lane result is consumed.
    for (genvar g = 0; g < `LSU_LANES; g++) begin : g_chk
        a_slot_kept: assert property (@(posedge g_clk) disable iff (!g_resetn)
            slot_valid[g] && !pipe_prog[g] |=>
                slot_valid[g] && $stable(lsu_addr[g*`LSU_XLEN +: `LSU_XLEN]));
    end

endmodule

// File: source/lsu_lane.sv
// --------------------------------------------------------------------------
// One load/store lane. Inputs must stay stable while lsu_valid is high.
// Only misalignment is reported as an error. Load data is valid for loads
// only, and reads as zero for stores.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_lane (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   lsu_valid,
    input  logic                   lsu_load,
    input  logic                   lsu_store,
    input  lsu_pkg::lsu_width_t    lsu_width,
    input  logic                   lsu_signed,
    input  logic [`LSU_XLEN-1:0]   lsu_addr,
    input  logic [`LSU_XLEN-1:0]   lsu_wdata,
    input  logic                   pipe_prog,
    output logic                   lsu_ready,
    output logic                   lsu_a_error,
    output logic                   dmem_req,
    output logic                   dmem_wen,
    output logic [3:0]             dmem_strb,
    output logic [`LSU_XLEN-1:0]   dmem_addr,
    output logic [`LSU_XLEN-1:0]   dmem_wdata,
    input  logic                   dmem_gnt,
    input  logic [`LSU_XLEN-1:0]   dmem_rdata,
    output logic [`LSU_XLEN-1:0]   res_rdata
);

    import lsu_pkg::*;

    logic                 lsu_finished;                // Done, waiting for consume.
    logic                 dmem_txn_done;               // Granted this cycle.
    logic [`LSU_XLEN-1:0] rdata_q;                     // Load data held under hold.
    logic [`LSU_XLEN-1:0] ld_data;
    logic [7:0]           ld_byte;
    logic [15:0]          ld_half;
    mem_word_t            rword;

    // ----------------------------------------------------------------------
    // Completion tracking
    // ----------------------------------------------------------------------
    assign dmem_txn_done = dmem_req && dmem_gnt;
    assign lsu_ready     = dmem_txn_done || lsu_finished ||
                           (lsu_valid && lsu_a_error);  // Errors finish at once.

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lsu_finished <= 1'b0;
        end else begin
            lsu_finished <= lsu_ready && !pipe_prog;    // Hold keeps it set.
        end
    end

    assign lsu_a_error = (lsu_width == LSU_HALF &&  lsu_addr[0]) ||
                         (lsu_width == LSU_WORD && |lsu_addr[1:0]);

    // ----------------------------------------------------------------------
    // Memory request
    // ----------------------------------------------------------------------
    assign dmem_req  = lsu_valid && !lsu_finished && !lsu_a_error;
    assign dmem_wen  = lsu_store;
    assign dmem_addr = {lsu_addr[`LSU_XLEN-1:2], 2'b00};   // Word aligned.

    always_comb begin
        case (lsu_width)
            LSU_BYTE: begin
                dmem_strb  = 4'b0001 << lsu_addr[1:0];
                dmem_wdata = `LSU_XLEN'(lsu_wdata[7:0]) << {lsu_addr[1:0], 3'b000};
            end
            LSU_HALF: begin
                dmem_strb  = 4'b0011 << {lsu_addr[1], 1'b0};
                dmem_wdata = `LSU_XLEN'(lsu_wdata[15:0]) << {lsu_addr[1], 4'b0000};
            end
            default: begin
                dmem_strb  = 4'b1111;
                dmem_wdata = lsu_wdata;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Load extraction
    // ----------------------------------------------------------------------
    assign rword   = dmem_rdata;
    assign ld_byte = rword.b[lsu_addr[1:0]];
    assign ld_half = rword.h[lsu_addr[1]];

    always_comb begin
        case (lsu_width)
            LSU_BYTE: ld_data = {{(`LSU_XLEN-8){lsu_signed && ld_byte[7]}}, ld_byte};
            LSU_HALF: ld_data = {{(`LSU_XLEN-16){lsu_signed && ld_half[15]}}, ld_half};
            default:  ld_data = rword;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (dmem_txn_done && !pipe_prog) begin
            rdata_q <= ld_data;                          // Grant under hold.
        end
    end

    assign res_rdata = !lsu_load    ? '0      :
                       lsu_finished ? rdata_q : ld_data;

    // A request carries only a legal width on its natural boundary.
    a_no_err_req: assert property (@(posedge g_clk) disable iff (!g_resetn)
        dmem_req |-> (lsu_width == LSU_BYTE) ||
                     (lsu_width == LSU_HALF && !lsu_addr[0]) ||
                     (lsu_width == LSU_WORD && lsu_addr[1:0] == 2'b00));

    a_strb_width: assert property (@(posedge g_clk) disable iff (!g_resetn)
        dmem_req |-> $countones(dmem_strb) ==
            ((lsu_width == LSU_BYTE) ? 1 : (lsu_width == LSU_HALF) ? 2 : 4));

endmodule

// File: source/dmem_arbiter.sv
// --------------------------------------------------------------------------
// Round-robin arbiter onto the single RAM port. The grant is combinational
// and assumes the RAM accepts every request in the same cycle.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_params.svh"

module dmem_arbiter (
    input  logic                                g_clk,
    input  logic                                g_resetn,
    input  logic [`LSU_LANES-1:0]               dmem_req,
    input  logic [`LSU_LANES-1:0]               dmem_wen,
    input  logic [4*`LSU_LANES-1:0]             dmem_strb,
    input  logic [`LSU_LANES*`LSU_XLEN-1:0]     dmem_addr,
    input  logic [`LSU_LANES*`LSU_XLEN-1:0]     dmem_wdata,
    output logic [`LSU_LANES-1:0]               dmem_gnt,
    output logic                                ram_en,
    output logic                                ram_wen,
    output logic [3:0]                          ram_strb,
    output logic [`LSU_XLEN-1:0]                ram_addr,
    output logic [`LSU_XLEN-1:0]                ram_wdata
);

    logic [`LSU_LANE_BITS-1:0] ptr;                    // Highest priority lane.
    logic [`LSU_LANE_BITS-1:0] win;                    // Granted lane index.

    // Search from the pointer, first requester wins.
    always_comb begin
        int idx;
        dmem_gnt = '0;
        win      = '0;
        for (int k = 0; k < `LSU_LANES; k++) begin
            idx = (int'(ptr) + k) % `LSU_LANES;
            if (dmem_req[idx] && dmem_gnt == '0) begin
                dmem_gnt[idx] = 1'b1;
                win           = `LSU_LANE_BITS'(idx);
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            ptr <= '0;
        end else if (|dmem_gnt) begin
            ptr <= (win == `LSU_LANE_BITS'(`LSU_LANES-1)) ? '0 : win + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Winner onto the RAM port
    // ----------------------------------------------------------------------
    assign ram_en    = |dmem_gnt;
    assign ram_wen   = ram_en && dmem_wen[win];
    assign ram_strb  = dmem_strb[win*4 +: 4];
    assign ram_addr  = dmem_addr[win*`LSU_XLEN +: `LSU_XLEN];
    assign ram_wdata = dmem_wdata[win*`LSU_XLEN +: `LSU_XLEN];

    a_gnt_onehot: assert property (@(posedge g_clk) disable iff (!g_resetn)
        $onehot0(dmem_gnt));

    a_gnt_req: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (dmem_gnt & ~dmem_req) == '0);

endmodule

// File: source/dmem_ram.sv
// --------------------------------------------------------------------------
// Word RAM with byte strobes. Reads are combinational, writes commit at
// the clock edge. Contents start at zero and are not reset.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_params.svh"

module dmem_ram (
    input  logic                   g_clk,
    input  logic                   ram_en,
    input  logic                   ram_wen,
    input  logic [3:0]             ram_strb,
    input  logic [`LSU_XLEN-1:0]   ram_addr,
    input  logic [`LSU_XLEN-1:0]   ram_wdata,
    output logic [`LSU_XLEN-1:0]   ram_rdata
);

    localparam int AW = $clog2(`LSU_RAM_WORDS);        // Word index width.

    logic [`LSU_XLEN-1:0] mem [`LSU_RAM_WORDS];
    logic [AW-1:0]        idx;

    assign idx = ram_addr[AW+1:2];                     // Upper bits ignored.

    initial begin
        for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (ram_en && ram_wen) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_strb[b]) mem[idx][8*b +: 8] <= ram_wdata[8*b +: 8];
            end
        end
    end

    assign ram_rdata = mem[idx];                       // Same-cycle answer.

endmodule

// File: source/lsu_cluster.sv
// --------------------------------------------------------------------------
// Load/store cluster top. One issue port feeds LSU_LANES lanes that share
// one on-chip RAM through a round-robin arbiter. Results are per lane.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_cluster (
    input  logic                                g_clk,
    input  logic                                g_resetn,
    input  logic                                req_valid,
    input  logic [`LSU_LANE_BITS-1:0]           req_lane,
    input  logic                                req_load,
    input  logic                                req_store,
    input  lsu_pkg::lsu_width_t                 req_width,
    input  logic                                req_signed,
    input  logic [`LSU_XLEN-1:0]                req_addr,
    input  logic [`LSU_XLEN-1:0]                req_wdata,
    output logic                                req_ready,
    output logic [`LSU_LANES-1:0]               res_valid,
    output logic [`LSU_LANES-1:0]               res_error,
    output logic [`LSU_LANES*`LSU_XLEN-1:0]     res_rdata,
    input  logic [`LSU_LANES-1:0]               res_hold
);

    import lsu_pkg::*;

    // ----------------------------------------------------------------------
    // Issue to lane wiring
    // ----------------------------------------------------------------------
    logic [`LSU_LANES-1:0]           lane_valid, lane_load, lane_store, lane_signed;
    logic [2*`LSU_LANES-1:0]         lane_width;
    logic [`LSU_LANES*`LSU_XLEN-1:0] lane_addr, lane_wdata;
    logic [`LSU_LANES-1:0]           lane_prog, lane_ready, lane_a_error;

    // Lane to arbiter wiring.
    logic [`LSU_LANES-1:0]           dmem_req, dmem_wen, dmem_gnt;
    logic [4*`LSU_LANES-1:0]         dmem_strb;
    logic [`LSU_LANES*`LSU_XLEN-1:0] dmem_addr, dmem_wdata;

    // Arbiter to RAM wiring.
    logic                 ram_en, ram_wen;
    logic [3:0]           ram_strb;
    logic [`LSU_XLEN-1:0] ram_addr, ram_wdata, ram_rdata;

    lsu_issue u_issue (
        .g_clk, .g_resetn,
        .req_valid, .req_lane, .req_load, .req_store,
        .req_width, .req_signed, .req_addr, .req_wdata, .req_ready,
        .res_hold, .res_valid, .res_error,
        .lane_ready   (lane_ready),
        .lane_a_error (lane_a_error),
        .lsu_valid    (lane_valid),
        .lsu_load     (lane_load),
        .lsu_store    (lane_store),
        .lsu_width    (lane_width),
        .lsu_signed   (lane_signed),
        .lsu_addr     (lane_addr),
        .lsu_wdata    (lane_wdata),
        .pipe_prog    (lane_prog)
    );

    for (genvar i = 0; i < `LSU_LANES; i++) begin : g_lane
        lsu_lane u_lane (
            .g_clk, .g_resetn,
            .lsu_valid   (lane_valid[i]),
            .lsu_load    (lane_load[i]),
            .lsu_store   (lane_store[i]),
            .lsu_width   (lsu_width_t'(lane_width[2*i +: 2])),
            .lsu_signed  (lane_signed[i]),
            .lsu_addr    (lane_addr[i*`LSU_XLEN +: `LSU_XLEN]),
            .lsu_wdata   (lane_wdata[i*`LSU_XLEN +: `LSU_XLEN]),
            .pipe_prog   (lane_prog[i]),
            .lsu_ready   (lane_ready[i]),
            .lsu_a_error (lane_a_error[i]),
            .dmem_req    (dmem_req[i]),
            .dmem_wen    (dmem_wen[i]),
            .dmem_strb   (dmem_strb[4*i +: 4]),
            .dmem_addr   (dmem_addr[i*`LSU_XLEN +: `LSU_XLEN]),
            .dmem_wdata  (dmem_wdata[i*`LSU_XLEN +: `LSU_XLEN]),
            .dmem_gnt    (dmem_gnt[i]),
            .dmem_rdata  (ram_rdata),                  // Broadcast to all lanes.
            .res_rdata   (res_rdata[i*`LSU_XLEN +: `LSU_XLEN])
        );
    end

    dmem_arbiter u_arb (
        .g_clk, .g_resetn,
        .dmem_req, .dmem_wen, .dmem_strb, .dmem_addr, .dmem_wdata, .dmem_gnt,
        .ram_en, .ram_wen, .ram_strb, .ram_addr, .ram_wdata
    );

    dmem_ram u_ram (
        .g_clk,
        .ram_en, .ram_wen, .ram_strb, .ram_addr, .ram_wdata, .ram_rdata
    );

endmodule

// File: dv/tb_lsu_cluster.sv
// --------------------------------------------------------------------------
// Random testbench for the load/store cluster. Each lane works only in its
// own slice of the RAM, so the order of RAM accesses across lanes is not
// observed. Load data is checked for aligned loads only.
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "lsu_params.svh"

module tb_lsu_cluster;

    import lsu_pkg::*;

    localparam int XL         = `LSU_XLEN;
    localparam int NUM_OPS    = 1500;
    localparam int RESET_CYC  = 16;
    localparam int MAX_CYCLES = NUM_OPS * (`LSU_LANES + 8) + RESET_CYC;
    localparam int LANE_WORDS = `LSU_RAM_WORDS / `LSU_LANES;  // Words per lane slice.

    logic                          g_clk;
    logic                          g_resetn;
    logic                          req_valid;
    logic [`LSU_LANE_BITS-1:0]     req_lane;
    logic                          req_load;
    logic                          req_store;
    lsu_width_t                    req_width;
    logic                          req_signed;
    logic [XL-1:0]                 req_addr;
    logic [XL-1:0]                 req_wdata;
    logic                          req_ready;
    logic [`LSU_LANES-1:0]         res_valid;
    logic [`LSU_LANES-1:0]         res_error;
    logic [`LSU_LANES*XL-1:0]      res_rdata;
    logic [`LSU_LANES-1:0]         res_hold;

    // ----------------------------------------------------------------------
    // Reference model state
    // ----------------------------------------------------------------------
    mem_word_t             shadow [`LSU_RAM_WORDS];        // Expected RAM image.
    logic [`LSU_LANES-1:0] exp_busy;                       // Slot holds an operation.
    logic                  exp_load   [`LSU_LANES];
    logic                  exp_store  [`LSU_LANES];
    lsu_width_t            exp_width  [`LSU_LANES];
    logic                  exp_signed [`LSU_LANES];
    logic [XL-1:0]         exp_addr   [`LSU_LANES];
    logic [XL-1:0]         exp_wdata  [`LSU_LANES];
    logic                  held       [`LSU_LANES];        // Result seen under hold.
    logic [XL-1:0]         held_rdata [`LSU_LANES];
    int                    errors;
    int                    issued;
    int                    results;
    int                    cycles = 0;
    logic                  have_op;                        // Operation on the bus.

    lsu_cluster UUT (.*);

    always #20 g_clk = ~g_clk;                             // 40 ns period.

    // Run limit.
    always @(posedge g_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Operations %0d, results %0d, errors %0d", issued, results, errors);
            $display("Verification failed");
            $finish;
        end
    end

    // Half or word access off its natural boundary.
    function automatic logic misaligned(lsu_width_t w, logic [1:0] lo);
        return (w == LSU_HALF && lo[0]) || (w == LSU_WORD && lo != 2'b00);
    endfunction

    function automatic logic [XL-1:0] load_value(mem_word_t w, lsu_width_t wd,
                                                 logic [1:0] lo, logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        b = w.b[lo];
        h = w.h[lo[1]];
        case (wd)
            LSU_BYTE: return sgn ? {{24{b[7]}}, b} : {24'h0, b};
            LSU_HALF: return sgn ? {{16{h[15]}}, h} : {16'h0, h};
            default:  return w;
        endcase
    endfunction

    // Merge a consumed store into the shadow RAM.
    task automatic store_commit(int l);
        int idx;
        idx = int'(exp_addr[l] >> 2) % `LSU_RAM_WORDS;
        case (exp_width[l])
            LSU_BYTE: shadow[idx].b[exp_addr[l][1:0]] = exp_wdata[l][7:0];
            LSU_HALF: shadow[idx].h[exp_addr[l][1]]   = exp_wdata[l][15:0];
            default:  shadow[idx]                     = exp_wdata[l];
        endcase
    endtask

    task automatic make_op();
        int lane;
        int w;
        int size;
        int off;
        lane = $urandom % `LSU_LANES;
        w    = $urandom % 3;
        off  = $urandom % (LANE_WORDS * 4);
        if ($urandom % 10 == 0) begin                      // About one in ten misaligned.
            if (w == 0) w = 2;
            size = 1 << w;
            off  = (off & ~(size - 1)) + 1 + ($urandom % (size - 1));
        end else begin
            size = 1 << w;
            off  = off & ~(size - 1);
        end
        req_lane   = `LSU_LANE_BITS'(lane);
        req_width  = lsu_width_t'(w[1:0]);
        req_store  = $urandom % 2 == 1;
        req_load   = !req_store;
        req_signed = $urandom % 2 == 1;
        req_addr   = XL'(lane * LANE_WORDS * 4 + off);     // Inside the lane slice.
        req_wdata  = $urandom;
    endtask

    // Compare every lane's result with the model, then retire what is taken.
    task automatic check_lanes();
        logic [XL-1:0] got;
        logic [XL-1:0] want;
        logic          mis;
        for (int l = 0; l < `LSU_LANES; l++) begin
            got = res_rdata[l*XL +: XL];
            mis = misaligned(exp_width[l], exp_addr[l][1:0]);
            if (!exp_busy[l]) begin
                assert (!res_valid[l]) else begin
                    errors++;
                    $display("Lane %0d gave a result with no operation pending", l);
                end
            end else begin
                if (held[l]) begin
                    assert (res_valid[l]) else begin
                        errors++;
                        $display("Lane %0d dropped its result while held", l);
                    end
                    assert (mis || got == held_rdata[l]) else begin
                        errors++;
                        $display("ERROR lane %0d res_rdata under hold exp %08h got %08h",
                                 l, held_rdata[l], got);
                    end
                end
                if (res_valid[l]) begin
                    assert (res_error[l] == mis) else begin
                        errors++;
                        $display("ERROR lane %0d res_error exp %0h got %0h",
                                 l, mis, res_error[l]);
                    end
                    if (exp_load[l] && !mis) begin
                        want = load_value(shadow[int'(exp_addr[l] >> 2) % `LSU_RAM_WORDS],
                                          exp_width[l], exp_addr[l][1:0], exp_signed[l]);
                        assert (got == want) else begin
                            errors++;
                            $display("ERROR lane %0d res_rdata exp %08h got %08h",
                                     l, want, got);
                        end
                    end
                    if (!res_hold[l]) begin                // Consumed at this edge.
                        if (exp_store[l] && !mis) store_commit(l);
                        exp_busy[l] = 1'b0;
                    end
                end
            end
            if (res_valid[l] && !res_hold[l]) results++;   // Results handed over by the DUT.
            held[l]       = exp_busy[l] && res_valid[l] && res_hold[l];
            held_rdata[l] = got;
        end
    endtask

    initial begin
        void'($urandom(32'h2419));
        g_clk      = 1'b0;
        g_resetn   = 1'b0;
        req_valid  = 1'b0;
        req_lane   = '0;
        req_load   = 1'b0;
        req_store  = 1'b0;
        req_width  = LSU_BYTE;
        req_signed = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        res_hold   = '0;
        errors     = 0;
        issued     = 0;
        results    = 0;
        have_op    = 1'b0;
        exp_busy   = '0;
        for (int i = 0; i < `LSU_RAM_WORDS; i++) shadow[i] = '0;
        for (int l = 0; l < `LSU_LANES; l++) begin
            held[l]       = 1'b0;
            held_rdata[l] = '0;
        end

        repeat (RESET_CYC) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        #5;
        for (int l = 0; l < `LSU_LANES; l++) begin         // Idle state after reset.
            req_lane = `LSU_LANE_BITS'(l);
            #1;
            assert (req_ready && res_valid == '0) else begin
                errors++;
                $display("Lane %0d is not idle after reset", l);
            end
        end

        // ------------------------------------------------------------------
        // Random traffic
        // ------------------------------------------------------------------
        while (issued < NUM_OPS || exp_busy != '0) begin
            @(negedge g_clk);
            for (int l = 0; l < `LSU_LANES; l++) res_hold[l] = ($urandom % 3 == 0);
            if (issued < NUM_OPS) begin
                if (!have_op) make_op();
                have_op   = 1'b1;
                req_valid = ($urandom % 4 != 0);
            end else begin
                req_valid = 1'b0;
            end
            #5;
            assert (req_ready == !exp_busy[req_lane]) else begin
                errors++;
                $display("ERROR req_ready lane %0d exp %0h got %0h",
                         req_lane, !exp_busy[req_lane], req_ready);
            end
            check_lanes();
            if (req_valid && req_ready) begin              // Slot fills at this edge.
                exp_busy[req_lane]   = 1'b1;
                exp_load[req_lane]   = req_load;
                exp_store[req_lane]  = req_store;
                exp_width[req_lane]  = req_width;
                exp_signed[req_lane] = req_signed;
                exp_addr[req_lane]   = req_addr;
                exp_wdata[req_lane]  = req_wdata;
                have_op              = 1'b0;
                issued++;
            end
        end

        assert (results == issued) else begin
            errors++;
            $display("Result count does not match the accepted operation count");
        end
        $display("Operations %0d, results %0d, errors %0d", issued, results, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+source
source/lsu_pkg.sv
source/lsu_issue.sv
source/lsu_lane.sv
source/dmem_arbiter.sv
source/dmem_ram.sv
source/lsu_cluster.sv
dv/tb_lsu_cluster.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the load/store cluster testbench with Verilator.
# Exits non-zero on a build error, a simulator error or a failed check.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_tb

if ! verilator --binary --timing --assert -Wno-fatal \
        -f list.f --top-module tb_lsu_cluster -Mdir "$OBJ" -o "$BIN"; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
exit 0
